//--- hw/fpnc_pkg.sv
/* Shared widths, encodings and types of the binary32 non-arithmetic FPU
   Imported by the operand classifier, the operation logic and the top level */

`default_nettype none

package fpnc_pkg;

  // ------------------
  // Format widths
  // ------------------
  // Operand and result word
  localparam int unsigned FP_W    = 32;
  // Exponent and mantissa fields of binary32
  localparam int unsigned EXP_W   = 8;
  localparam int unsigned MAN_W   = 23;
  // One-hot class mask
  localparam int unsigned CLASS_W = 10;

  // ------------------
  // Operation encodings
  // ------------------
  typedef enum logic [1:0] {
    OP_SGNJ     = 2'd0,
    OP_MINMAX   = 2'd1,
    OP_CMP      = 2'd2,
    OP_CLASSIFY = 2'd3
  } fpnc_op_e;

  // Variant select, meaning depends on the operation
  // SUB_0 is SGNJ, MIN or LE
  // SUB_1 is SGNJN, MAX or LT
  // SUB_2 is SGNJX or EQ
  // SUB_3 is sign injection passthrough
  typedef enum logic [2:0] {
    SUB_0 = 3'd0,
    SUB_1 = 3'd1,
    SUB_2 = 3'd2,
    SUB_3 = 3'd3
  } fpnc_sub_e;

  // Class mask, one bit per class
  typedef enum logic [CLASS_W-1:0] {
    NEGINF  = 10'b00_0000_0001,
    NEGNORM = 10'b00_0000_0010,
    NEGSUB  = 10'b00_0000_0100,
    NEGZERO = 10'b00_0000_1000,
    POSZERO = 10'b00_0001_0000,
    POSSUB  = 10'b00_0010_0000,
    POSNORM = 10'b00_0100_0000,
    POSINF  = 10'b00_1000_0000,
    SNAN    = 10'b01_0000_0000,
    QNAN    = 10'b10_0000_0000
  } fpnc_class_e;

  // ------------------
  // Operand word
  // ------------------
  // Field view of a binary32 value
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exponent;
    logic [MAN_W-1:0] mantissa;
  } fp_fields_t;

  // Same word seen as fields or as a plain unsigned number
  // The raw view gives magnitude ordering for equal signs
  typedef union packed {
    fp_fields_t      fields;
    logic [FP_W-1:0] raw;
  } fp_word_u;

  // Canonical quiet NaN, positive with only the top mantissa bit set
  localparam logic [FP_W-1:0] QNAN_WORD = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MAN_W-1){1'b0}}};

  // Operand classification flags
  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

endpackage

`default_nettype wire

//--- hw/fpnc_pipe_regs.sv
/* Chain of valid/ready register stages for a payload of any width
   A count of zero gives a plain wire path from input to output */

`timescale 1ns/10ps
`default_nettype none

module fpnc_pipe_regs #(
  parameter int unsigned DATA_W   = 32,
  parameter int unsigned NUM_REGS = 1
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Upstream side
  input  logic              valid_i,
  input  logic [DATA_W-1:0] data_i,
  output logic              ready_o,
  // Downstream side
  output logic              valid_o,
  output logic [DATA_W-1:0] data_o,
  input  logic              ready_i
);

  // Index k holds the item after k register stages
  logic [DATA_W-1:0] stage_data  [0:NUM_REGS];
  logic              stage_valid [0:NUM_REGS];
  // Ready travels backwards and is combinational
  logic              stage_ready [0:NUM_REGS];

  // ------------------
  // Chain entry
  // ------------------
  assign stage_data[0]  = data_i;
  assign stage_valid[0] = valid_i;
  assign ready_o        = stage_ready[0];

  // ------------------
  // Register stages
  // ------------------
  for (genvar k = 0; k < NUM_REGS; k++) begin : gen_stage
    logic load_en;

    // Stage can take an item when empty downstream or when its item moves on
    assign stage_ready[k] = stage_ready[k+1] | ~stage_valid[k+1];

    // Payload only loads for a real item, bubbles leave it untouched
    assign load_en = stage_ready[k] & stage_valid[k];

    // Valid bit follows upstream whenever the stage is ready
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        stage_valid[k+1] <= 1'b0;
      end else if (stage_ready[k]) begin
        stage_valid[k+1] <= stage_valid[k];
      end
    end

    // Payload register
    always_ff @(posedge clk_i) begin
      if (load_en) begin
        stage_data[k+1] <= stage_data[k];
      end
    end
  end

  // ------------------
  // Chain exit
  // ------------------
  assign stage_ready[NUM_REGS] = ready_i;
  assign valid_o               = stage_valid[NUM_REGS];
  assign data_o                = stage_data[NUM_REGS];

  // Item held by back-pressure is still offered next cycle
  a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o);

  // Held item keeps its payload
  a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> $stable(data_o));

endmodule

`default_nettype wire

//--- hw/fpnc_operand_class.sv
/* Classifies one binary32 operand from its exponent and mantissa fields
   Purely combinational, one instance per operand */

`timescale 1ns/10ps
`default_nettype none

module fpnc_operand_class (
  input  fpnc_pkg::fp_word_u word_i,
  output fpnc_pkg::fp_info_t info_o
);

  import fpnc_pkg::*;

  logic exp_zero;
  logic exp_ones;
  logic man_zero;

  // Field tests
  assign exp_zero = (word_i.fields.exponent == '0);
  assign exp_ones = (word_i.fields.exponent == '1);
  assign man_zero = (word_i.fields.mantissa == '0);

  // Zero exponent splits into zero and subnormal by mantissa
  assign info_o.is_zero      = exp_zero & man_zero;
  assign info_o.is_subnormal = exp_zero & ~man_zero;

  // Any other finite exponent
  assign info_o.is_normal    = ~exp_zero & ~exp_ones;

  // All-ones exponent splits into infinity and NaN
  assign info_o.is_inf       = exp_ones & man_zero;
  assign info_o.is_nan       = exp_ones & ~man_zero;

  // Quiet bit is the top mantissa bit
  // Signalling when it is clear
  assign info_o.is_signalling = exp_ones & ~man_zero & ~word_i.fields.mantissa[MAN_W-1];

endmodule

`default_nettype wire

//--- hw/fpnc_ops.sv
/* Sign injection, min/max, comparison and classification of binary32 operands
   Purely combinational, placed between the input and output register chains */

`timescale 1ns/10ps
`default_nettype none

module fpnc_ops (
  input  fpnc_pkg::fp_word_u  opa_i,
  input  fpnc_pkg::fp_word_u  opb_i,
  input  fpnc_pkg::fpnc_op_e  op_i,
  input  fpnc_pkg::fpnc_sub_e sub_i,
  input  logic                op_mod_i,
  output fpnc_pkg::fp_word_u  result_o,
  output logic                invalid_o
);

  import fpnc_pkg::*;

  // ------------------
  // Operand classes
  // ------------------
  fp_info_t info_a;
  fp_info_t info_b;

  fpnc_operand_class u_class_a (
    .word_i ( opa_i  ),
    .info_o ( info_a )
  );

  fpnc_operand_class u_class_b (
    .word_i ( opb_i  ),
    .info_o ( info_b )
  );

  // Special case reductions
  logic any_nan;
  logic both_nan;
  logic any_snan;

  assign any_nan  = info_a.is_nan | info_b.is_nan;
  assign both_nan = info_a.is_nan & info_b.is_nan;
  assign any_snan = info_a.is_signalling | info_b.is_signalling;

  // ------------------
  // Shared ordering
  // ------------------
  logic operands_equal;
  logic a_smaller;

  // Plus and minus zero count as equal
  assign operands_equal = (opa_i.raw == opb_i.raw) | (info_a.is_zero & info_b.is_zero);

  // Unsigned order of the raw words flips once a negative sign is involved
  assign a_smaller = (opa_i.raw < opb_i.raw) ^ (opa_i.fields.sign | opb_i.fields.sign);

  // ------------------
  // Sign injection
  // ------------------
  fp_word_u sgnj_res;

  always_comb begin : sign_inject
    // Start from a, only the sign changes
    sgnj_res = opa_i;
    unique case (sub_i)
      SUB_0:   sgnj_res.fields.sign = opb_i.fields.sign;
      SUB_1:   sgnj_res.fields.sign = ~opb_i.fields.sign;
      SUB_2:   sgnj_res.fields.sign = opa_i.fields.sign ^ opb_i.fields.sign;
      // Passthrough and unused codes keep a as is
      default: sgnj_res = opa_i;
    endcase
  end

  // ------------------
  // Min / max
  // ------------------
  fp_word_u minmax_res;
  logic     minmax_invalid;

  // Quiet ordering, only signalling NaNs raise invalid
  assign minmax_invalid = any_snan;

  always_comb begin : min_max
    if (both_nan) begin
      minmax_res.raw = QNAN_WORD;
    end else if (info_a.is_nan) begin
      // One NaN yields the other operand
      minmax_res = opb_i;
    end else if (info_b.is_nan) begin
      minmax_res = opa_i;
    end else begin
      unique case (sub_i)
        // Ties such as +0 against -0 return a
        SUB_0:   minmax_res = (a_smaller | operands_equal) ? opa_i : opb_i;
        SUB_1:   minmax_res = (a_smaller & ~operands_equal) ? opb_i : opa_i;
        default: minmax_res = opa_i;
      endcase
    end
  end

  // ------------------
  // Comparison
  // ------------------
  logic cmp_flag;
  logic cmp_invalid;

  always_comb begin : compare
    cmp_flag    = 1'b0;
    cmp_invalid = 1'b0;
    // Signalling NaN is always false and invalid
    if (any_snan) begin
      cmp_invalid = 1'b1;
    end else begin
      unique case (sub_i)
        // LE and LT are signalling comparisons, quiet NaN is invalid too
        SUB_0: begin
          if (any_nan) cmp_invalid = 1'b1;
          else         cmp_flag    = (a_smaller | operands_equal) ^ op_mod_i;
        end
        SUB_1: begin
          if (any_nan) cmp_invalid = 1'b1;
          else         cmp_flag    = (a_smaller & ~operands_equal) ^ op_mod_i;
        end
        // EQ is quiet, NaN is never equal
        SUB_2: begin
          if (any_nan) cmp_flag = op_mod_i;
          else         cmp_flag = operands_equal ^ op_mod_i;
        end
        default: cmp_flag = 1'b0;
      endcase
    end
  end

  // ------------------
  // Classification
  // ------------------
  fpnc_class_e class_mask;

  always_comb begin : classify
    if (info_a.is_normal) begin
      class_mask = opa_i.fields.sign ? NEGNORM : POSNORM;
    end else if (info_a.is_subnormal) begin
      class_mask = opa_i.fields.sign ? NEGSUB : POSSUB;
    end else if (info_a.is_zero) begin
      class_mask = opa_i.fields.sign ? NEGZERO : POSZERO;
    end else if (info_a.is_inf) begin
      class_mask = opa_i.fields.sign ? NEGINF : POSINF;
    end else if (info_a.is_signalling) begin
      class_mask = SNAN;
    end else begin
      class_mask = QNAN;
    end
  end

  // ------------------
  // Result select
  // ------------------
  always_comb begin : select_result
    unique case (op_i)
      OP_SGNJ: begin
        result_o  = sgnj_res;
        invalid_o = 1'b0;
      end
      OP_MINMAX: begin
        result_o  = minmax_res;
        invalid_o = minmax_invalid;
      end
      OP_CMP: begin
        result_o.raw = {{(FP_W-1){1'b0}}, cmp_flag};
        invalid_o    = cmp_invalid;
      end
      // Mask returns in the low bits of the word
      default: begin
        result_o.raw = {{(FP_W-CLASS_W){1'b0}}, class_mask};
        invalid_o    = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/fpnc_top.sv
/* Top level of the binary32 non-arithmetic FPU with valid/ready handshakes
   Request goes through the input chain, the operation logic and the output chain */

`timescale 1ns/10ps
`default_nettype none

module fpnc_top #(
  parameter int unsigned NUM_INP_REGS = 1,
  parameter int unsigned NUM_OUT_REGS = 1,
  parameter int unsigned TAG_W        = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Request side
  input  logic                      in_valid_i,
  input  logic [fpnc_pkg::FP_W-1:0] opa_i,
  input  logic [fpnc_pkg::FP_W-1:0] opb_i,
  input  fpnc_pkg::fpnc_op_e        op_i,
  input  fpnc_pkg::fpnc_sub_e       sub_i,
  input  logic                      op_mod_i,
  input  logic [TAG_W-1:0]          tag_i,
  output logic                      in_ready_o,
  // Result side
  output logic                      out_valid_o,
  output logic [fpnc_pkg::FP_W-1:0] result_o,
  output logic                      invalid_o,
  output logic [TAG_W-1:0]          tag_o,
  input  logic                      out_ready_i
);

  import fpnc_pkg::*;

  // Payload widths of the two chains
  localparam int unsigned OP_W  = $bits(fpnc_op_e);
  localparam int unsigned SUB_W = $bits(fpnc_sub_e);
  localparam int unsigned INP_W = 2 * FP_W + OP_W + SUB_W + 1 + TAG_W;
  localparam int unsigned OUT_W = FP_W + 1 + TAG_W;

  logic [INP_W-1:0] inp_data_d;
  logic [INP_W-1:0] inp_data_q;
  logic [OUT_W-1:0] out_data_d;
  logic [OUT_W-1:0] out_data_q;

  // Handshake between the two chains
  logic mid_valid;
  logic mid_ready;

  // Request fields after the input chain
  logic [FP_W-1:0]  mid_opa;
  logic [FP_W-1:0]  mid_opb;
  logic [OP_W-1:0]  mid_op;
  logic [SUB_W-1:0] mid_sub;
  logic             mid_op_mod;
  logic [TAG_W-1:0] mid_tag;

  fp_word_u ops_result;
  logic     ops_invalid;

  // ------------------
  // Input chain
  // ------------------
  assign inp_data_d = {opa_i, opb_i, op_i, sub_i, op_mod_i, tag_i};

  fpnc_pipe_regs #(
    .DATA_W   ( INP_W        ),
    .NUM_REGS ( NUM_INP_REGS )
  ) u_inp_regs (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .valid_i ( in_valid_i ),
    .data_i  ( inp_data_d ),
    .ready_o ( in_ready_o ),
    .valid_o ( mid_valid  ),
    .data_o  ( inp_data_q ),
    .ready_i ( mid_ready  )
  );

  assign {mid_opa, mid_opb, mid_op, mid_sub, mid_op_mod, mid_tag} = inp_data_q;

  // ------------------
  // Operation logic
  // ------------------
  fpnc_ops u_ops (
    .opa_i     ( mid_opa                 ),
    .opb_i     ( mid_opb                 ),
    .op_i      ( fpnc_op_e'(mid_op)      ),
    .sub_i     ( fpnc_sub_e'(mid_sub)    ),
    .op_mod_i  ( mid_op_mod              ),
    .result_o  ( ops_result              ),
    .invalid_o ( ops_invalid             )
  );

  // ------------------
  // Output chain
  // ------------------
  // Tag bypasses the operation logic
  assign out_data_d = {ops_result.raw, ops_invalid, mid_tag};

  fpnc_pipe_regs #(
    .DATA_W   ( OUT_W        ),
    .NUM_REGS ( NUM_OUT_REGS )
  ) u_out_regs (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .valid_i ( mid_valid   ),
    .data_i  ( out_data_d  ),
    .ready_o ( mid_ready   ),
    .valid_o ( out_valid_o ),
    .data_o  ( out_data_q  ),
    .ready_i ( out_ready_i )
  );

  assign {result_o, invalid_o, tag_o} = out_data_q;

endmodule

`default_nettype wire

//--- bench/fpnc_tb_checks.svh
/* Concurrent checks of the FPU output port against the expectation queue head
   Included at the end of the testbench module body, sampled mid-cycle */

`ifndef FPNC_TB_CHECKS_SVH
`define FPNC_TB_CHECKS_SVH

  // --------------------
  // Output transfers
  // --------------------
  // Nothing may leave that was never accepted
  a_out_expected: assert property (@(negedge clk_i) disable iff (!rst_n_i)
      out_valid_o && out_ready_i |-> head_valid)
    else fail_stop("Output transfer with no accepted request waiting for it");

  a_result_match: assert property (@(negedge clk_i) disable iff (!rst_n_i)
      out_valid_o && out_ready_i && head_valid |-> result_o == head_result)
    else fail_stop($sformatf("FAIL at %0t: result_o expected %h actual %h",
                             $time, head_result, result_o));

  a_invalid_match: assert property (@(negedge clk_i) disable iff (!rst_n_i)
      out_valid_o && out_ready_i && head_valid |-> invalid_o == head_invalid)
    else fail_stop($sformatf("FAIL at %0t: invalid_o expected %b actual %b",
                             $time, head_invalid, invalid_o));

  // Tag order proves no reorder, drop or duplicate
  a_tag_match: assert property (@(negedge clk_i) disable iff (!rst_n_i)
      out_valid_o && out_ready_i && head_valid |-> tag_o == head_tag)
    else fail_stop($sformatf("FAIL at %0t: tag_o expected %h actual %h",
                             $time, head_tag, tag_o));

  // --------------------
  // Back-pressure
  // --------------------
  a_valid_held: assert property (@(negedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o)
    else fail_stop("out_valid_o dropped while the output was stalled");

  a_payload_held: assert property (@(negedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i |=> $stable({result_o, invalid_o, tag_o}))
    else fail_stop("Output payload changed while the output was stalled");

  // Idle and ready right after reset release
  a_reset_idle: assert property (@(negedge clk_i) disable iff (!rst_n_i)
      $rose(rst_n_i) |-> !out_valid_o && in_ready_o)
    else fail_stop("After reset the DUT is not idle with in_ready_o high");

`endif

//--- bench/fpnc_tb.sv
/* Testbench for the binary32 non-arithmetic FPU with directed and random requests
   Concurrent checks come from the included checks header at the end of the module */

`timescale 1ns/10ps
`default_nettype none

module fpnc_tb;

  import fpnc_pkg::*;

  localparam int TAG_W          = 4;
  localparam int TIMEOUT_CYCLES = 500;
  localparam int NUM_RANDOM     = 800;

  // Zeros, subnormals, normals, infinities, quiet and signalling NaNs of both signs
  localparam logic [31:0] SPECIAL_VALS [0:15] = '{
    32'h0000_0000, 32'h8000_0000, 32'h0000_0001, 32'h807f_ffff,
    32'h0040_0000, 32'h3f80_0000, 32'h4000_0000, 32'hbf80_0000,
    32'hc049_0fdb, 32'h7f7f_ffff, 32'h7f80_0000, 32'hff80_0000,
    32'h7fc0_0000, 32'hffc0_0123, 32'h7f80_0001, 32'hffa0_0000
  };

  // --------------------
  // Clock, reset, DUT
  // --------------------
  logic              clk_i = 1'b0;
  logic              rst_n_i;
  logic              in_valid_i;
  logic [31:0]       opa_i;
  logic [31:0]       opb_i;
  fpnc_op_e          op_i;
  fpnc_sub_e         sub_i;
  logic              op_mod_i;
  logic [TAG_W-1:0]  tag_i;
  logic              in_ready_o;
  logic              out_valid_o;
  logic [31:0]       result_o;
  logic              invalid_o;
  logic [TAG_W-1:0]  tag_o;
  logic              out_ready_i = 1'b1;

  integer            seed    = 57709;
  // Back-pressure draws from its own stream
  integer            bp_seed = 57709 + 1;
  logic [TAG_W-1:0]  tag_count = '0;

  always #10 clk_i = ~clk_i;

  fpnc_top dut_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .in_valid_i  ( in_valid_i  ),
    .opa_i       ( opa_i       ),
    .opb_i       ( opb_i       ),
    .op_i        ( op_i        ),
    .sub_i       ( sub_i       ),
    .op_mod_i    ( op_mod_i    ),
    .tag_i       ( tag_i       ),
    .in_ready_o  ( in_ready_o  ),
    .out_valid_o ( out_valid_o ),
    .result_o    ( result_o    ),
    .invalid_o   ( invalid_o   ),
    .tag_o       ( tag_o       ),
    .out_ready_i ( out_ready_i )
  );

  // Random output stall, about one cycle in four
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      out_ready_i <= (($random(bp_seed) & 3) != 0);
    end
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic logic is_nan_word(input logic [31:0] w);
    return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
  endfunction

  function automatic logic is_snan_word(input logic [31:0] w);
    return is_nan_word(w) && !w[22];
  endfunction

  // Monotonic key for non-NaN values, both zeros share one key
  function automatic logic [31:0] order_key(input logic [31:0] w);
    if (w[30:0] == 31'd0) begin
      return 32'h8000_0000;
    end
    return w[31] ? ~w : (w | 32'h8000_0000);
  endfunction

  function automatic logic [CLASS_W-1:0] class_of(input logic [31:0] w);
    logic s;
    s = w[31];
    if (w[30:23] == 8'hff) begin
      if (w[22:0] == 23'd0) return s ? NEGINF : POSINF;
      return w[22] ? QNAN : SNAN;
    end
    if (w[30:23] == 8'h00) begin
      if (w[22:0] == 23'd0) return s ? NEGZERO : POSZERO;
      return s ? NEGSUB : POSSUB;
    end
    return s ? NEGNORM : POSNORM;
  endfunction

  function automatic void compute_expected(input logic [31:0] a, input logic [31:0] b,
                                           input fpnc_op_e op, input fpnc_sub_e sub,
                                           input logic mod, output logic [31:0] res,
                                           output logic inv);
    logic [31:0] ka;
    logic [31:0] kb;
    logic        any_nan;
    logic        flag;
    ka      = order_key(a);
    kb      = order_key(b);
    any_nan = is_nan_word(a) || is_nan_word(b);
    flag    = 1'b0;
    res     = a;
    inv     = 1'b0;
    case (op)
      OP_SGNJ: begin
        if (sub == SUB_0) res = {b[31], a[30:0]};
        else if (sub == SUB_1) res = {~b[31], a[30:0]};
        else if (sub == SUB_2) res = {a[31] ^ b[31], a[30:0]};
      end
      OP_MINMAX: begin
        inv = is_snan_word(a) || is_snan_word(b);
        if (is_nan_word(a) && is_nan_word(b)) res = QNAN_WORD;
        else if (is_nan_word(a)) res = b;
        else if (is_nan_word(b)) res = a;
        // Ties keep a
        else if (sub == SUB_0) res = (kb < ka) ? b : a;
        else if (sub == SUB_1) res = (kb > ka) ? b : a;
      end
      OP_CMP: begin
        if (is_snan_word(a) || is_snan_word(b)) inv = 1'b1;
        else if (sub == SUB_2) flag = any_nan ? mod : ((ka == kb) ^ mod);
        else if (any_nan) inv = 1'b1;
        else if (sub == SUB_0) flag = (ka <= kb) ^ mod;
        else flag = (ka < kb) ^ mod;
        res = {31'd0, flag};
      end
      default: res = {22'd0, class_of(a)};
    endcase
  endfunction

  // --------------------
  // Expectation queue
  // --------------------
  logic [31:0]      exp_result_q [$];
  logic             exp_invalid_q [$];
  logic [TAG_W-1:0] exp_tag_q [$];
  logic             in_fire      = 1'b0;
  logic             out_fire     = 1'b0;
  logic [31:0]      pend_result  = '0;
  logic             pend_invalid = 1'b0;
  logic [TAG_W-1:0] pend_tag     = '0;
  logic             head_valid   = 1'b0;
  logic [31:0]      head_result  = '0;
  logic             head_invalid = 1'b0;
  logic [TAG_W-1:0] head_tag     = '0;

  // Mid-cycle, inputs and outputs are settled, so the next edge's transfers are known
  always @(negedge clk_i) begin
    in_fire  = rst_n_i && in_valid_i && in_ready_o;
    out_fire = rst_n_i && out_valid_o && out_ready_i;
    if (in_fire) begin
      compute_expected(opa_i, opb_i, op_i, sub_i, op_mod_i, pend_result, pend_invalid);
      pend_tag = tag_i;
    end
  end

  // Queue moves on the edge where the transfers happen
  always @(posedge clk_i) begin
    if (out_fire) begin
      void'(exp_result_q.pop_front());
      void'(exp_invalid_q.pop_front());
      void'(exp_tag_q.pop_front());
    end
    if (in_fire) begin
      exp_result_q.push_back(pend_result);
      exp_invalid_q.push_back(pend_invalid);
      exp_tag_q.push_back(pend_tag);
    end
    head_valid = (exp_tag_q.size() != 0);
    if (head_valid) begin
      head_result  = exp_result_q[0];
      head_invalid = exp_invalid_q[0];
      head_tag     = exp_tag_q[0];
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  // Offers one request and returns on the edge that accepts it
  task automatic send_item(input logic [31:0] a, input logic [31:0] b, input fpnc_op_e op,
                           input fpnc_sub_e sub, input logic mod);
    int waited;
    waited = 0;
    in_valid_i <= 1'b1;
    opa_i      <= a;
    opb_i      <= b;
    op_i       <= op;
    sub_i      <= sub;
    op_mod_i   <= mod;
    tag_i      <= tag_count;
    tag_count  = tag_count + 4'd1;
    @(posedge clk_i);
    while (!in_fire) begin
      if (waited == TIMEOUT_CYCLES) fail_stop("Timeout: the DUT never accepted a request");
      waited++;
      @(posedge clk_i);
    end
  endtask

  // Half special values, the rest NaN-heavy or fully random words
  task automatic pick_operand(output logic [31:0] w);
    logic [31:0] rnd;
    rnd = $random(seed);
    if (rnd[0]) w = SPECIAL_VALS[rnd[4:1]];
    else if (rnd[1]) w = {rnd[31], 8'hff, rnd[30:8]};
    else w = $random(seed);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (exp_tag_q.size() != 0) begin
      if (waited == TIMEOUT_CYCLES) fail_stop("Timeout: accepted requests never left the DUT");
      waited++;
      @(negedge clk_i);
    end
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rnd;
    fpnc_op_e    op;
    fpnc_sub_e   sub;
    rst_n_i    = 1'b0;
    in_valid_i = 1'b0;
    opa_i      = '0;
    opb_i      = '0;
    op_i       = OP_SGNJ;
    sub_i      = SUB_0;
    op_mod_i   = 1'b0;
    tag_i      = '0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);

    // Every pair of special values through every variant
    for (int i = 0; i < 16; i++) begin
      for (int j = 0; j < 16; j++) begin
        a = SPECIAL_VALS[i[3:0]];
        b = SPECIAL_VALS[j[3:0]];
        for (int s = 0; s < 4; s++) send_item(a, b, OP_SGNJ, fpnc_sub_e'(s[2:0]), 1'b0);
        for (int s = 0; s < 2; s++) send_item(a, b, OP_MINMAX, fpnc_sub_e'(s[2:0]), 1'b0);
        for (int s = 0; s < 3; s++) begin
          send_item(a, b, OP_CMP, fpnc_sub_e'(s[2:0]), 1'b0);
          send_item(a, b, OP_CMP, fpnc_sub_e'(s[2:0]), 1'b1);
        end
        send_item(a, b, OP_CLASSIFY, SUB_0, 1'b0);
      end
    end

    // Random operands and operations with idle gaps
    for (int n = 0; n < NUM_RANDOM; n++) begin
      pick_operand(a);
      pick_operand(b);
      rnd = $random(seed);
      op  = fpnc_op_e'(rnd[1:0]);
      case (op)
        OP_SGNJ:   sub = fpnc_sub_e'({1'b0, rnd[3:2]});
        OP_MINMAX: sub = fpnc_sub_e'({2'b00, rnd[2]});
        OP_CMP:    sub = (rnd[3:2] == 2'd3) ? SUB_2 : fpnc_sub_e'({1'b0, rnd[3:2]});
        default:   sub = SUB_0;
      endcase
      send_item(a, b, op, sub, rnd[4]);
      if (rnd[7:5] == 3'd0) begin
        in_valid_i <= 1'b0;
        @(posedge clk_i);
      end
    end

    in_valid_i <= 1'b0;
    wait_drained();
    $display("Simulation finished: PASS");
    $finish;
  end

  `include "fpnc_tb_checks.svh"

endmodule

`default_nettype wire

//--- verilog.f
+incdir+bench
hw/fpnc_pkg.sv
hw/fpnc_pipe_regs.sv
hw/fpnc_operand_class.sv
hw/fpnc_ops.sv
hw/fpnc_top.sv
bench/fpnc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the FPU testbench with Verilator, runs it and scans the log.
# Exits nonzero when the build fails or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
FAIL_MSG="Simulation finished: FAIL"

rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module fpnc_tb -Mdir "$BUILD_DIR" -o fpnc_sim -f verilog.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

# A crash without a message still counts as a failure
"./$BUILD_DIR/fpnc_sim" > "$LOG" 2>&1 || echo "$FAIL_MSG (simulator exit status)" >> "$LOG"

cat "$LOG"
grep -q "$FAIL_MSG" "$LOG" && { echo "Run failed"; exit 1; }
echo "Run passed" && exit 0
